//--- design/bus_mem_pkg.sv
package bus_mem_pkg;

	// bus widths
	localparam int unsigned ADR_WIDTH = 32;
	localparam int unsigned DAT_WIDTH = 32;
	localparam int unsigned SEL_WIDTH = DAT_WIDTH / 8;
	localparam int unsigned WORD_LSB = 2;

	typedef logic [ADR_WIDTH-1:0] bus_adr_t;
	typedef logic [DAT_WIDTH-1:0] bus_dat_t;
	typedef logic [SEL_WIDTH-1:0] bus_sel_t;

	// address map, slot number sits in bits 15..12
	localparam int unsigned SLAVE_NUMBER = 4;
	localparam int unsigned SLOT_LSB = 12;
	localparam int unsigned SLOT_MSB = 15;

	typedef logic [SLAVE_NUMBER-1:0] slave_cs_t;
	typedef logic [SLOT_MSB-SLOT_LSB:0] slot_t;

	localparam int unsigned SLOT_RAM0 = 0;
	localparam int unsigned SLOT_RAM1 = 1;
	localparam int unsigned SLOT_REG = 2;
	localparam int unsigned SLOT_EXT = 3;

	localparam int unsigned RAM0_WORDS = 256;
	localparam int unsigned RAM1_WORDS = 64;

	// register slave, word offsets taken modulo 4
	typedef logic [1:0] reg_ofs_t;

	localparam reg_ofs_t REG_GPIO_OUT = 2'd0;
	localparam reg_ofs_t REG_GPIO_IN = 2'd1;
	localparam reg_ofs_t REG_SCRATCH = 2'd2;
	localparam reg_ofs_t REG_ID = 2'd3;

	localparam bus_dat_t REG_ID_VALUE = 32'h4255_5331;

	localparam int unsigned GPIO_WIDTH = 8;
	typedef logic [GPIO_WIDTH-1:0] gpio_t;

endpackage

//--- design/bus_slave_selector.sv
`timescale 1ns/1ps

module bus_slave_selector (
	input  bus_mem_pkg::bus_adr_t  adr_i,
	input  logic                   stb_i,
	output bus_mem_pkg::slave_cs_t cs_o,
	output logic                   adr_err_o
);

	import bus_mem_pkg::*;

	slot_t slot;
	logic  upper_zero;
	logic  adr_valid;

	assign slot = adr_i[SLOT_MSB:SLOT_LSB];

	// everything above the slot field must be clear
	assign upper_zero = (adr_i[ADR_WIDTH-1:SLOT_MSB+1] == '0);

	assign adr_valid = upper_zero && (slot < SLAVE_NUMBER);

	// one bit per slot, only while a request is on the bus
	assign cs_o = (stb_i && adr_valid) ? (slave_cs_t'(1) << slot) : '0;

	assign adr_err_o = stb_i && !adr_valid;

	// at most one slave, and never a slave together with an error
	always_comb begin
		assert ($onehot0(cs_o) && !(adr_err_o && (|cs_o)))
			else $error("selector: bad select %b err %b", cs_o, adr_err_o);
	end

endmodule

//--- design/bus_switch.sv
`timescale 1ns/1ps

module bus_switch (
	// master side
	input  logic                                            master_stb_i,
	input  logic                                            master_we_i,
	input  bus_mem_pkg::bus_adr_t                           master_adr_i,
	input  bus_mem_pkg::bus_dat_t                           master_dat_i,
	input  bus_mem_pkg::bus_sel_t                           master_sel_i,
	output bus_mem_pkg::bus_dat_t                           master_dat_o,
	output logic                                            master_ack_o,
	output logic                                            adr_err_o,

	// slave side, one slot per bit or word
	output bus_mem_pkg::slave_cs_t                          slave_stb_o,
	output logic                                            slave_we_o,
	output bus_mem_pkg::bus_adr_t                           slave_adr_o,
	output bus_mem_pkg::bus_dat_t                           slave_dat_o,
	output bus_mem_pkg::bus_sel_t                           slave_sel_o,
	input  bus_mem_pkg::bus_dat_t [bus_mem_pkg::SLAVE_NUMBER-1:0] slave_dat_i,
	input  bus_mem_pkg::slave_cs_t                          slave_ack_i
);

	import bus_mem_pkg::*;

	slave_cs_t cs;

	bus_slave_selector bus_slave_selector_i (
		.adr_i     (master_adr_i),
		.stb_i     (master_stb_i),
		.cs_o      (cs),
		.adr_err_o (adr_err_o)
	);

	// request goes to every slot, only the strobe is per slot
	assign slave_stb_o = cs;
	assign slave_we_o  = master_we_i;
	assign slave_adr_o = master_adr_i;
	assign slave_dat_o = master_dat_i;
	assign slave_sel_o = master_sel_i;

	// and-or merge of the returned words
	always_comb begin
		master_dat_o = '0;
		for (int i = 0; i < SLAVE_NUMBER; i++) begin
			master_dat_o |= slave_dat_i[i] & {DAT_WIDTH{cs[i]}};
		end
	end

	assign master_ack_o = |(slave_ack_i & cs);

	// a slave ack must never leak out without an open request
	always_comb begin
		assert (!master_ack_o || master_stb_i)
			else $error("switch: ack without strobe");
	end

endmodule

//--- design/bus_ram_slave.sv
`timescale 1ns/1ps

module bus_ram_slave #(
	parameter int unsigned DEPTH_WORDS = 256
) (
	input  logic                  clk_i,
	input  logic                  arst_n_i,
	input  logic                  stb_i,
	input  logic                  we_i,
	input  bus_mem_pkg::bus_adr_t adr_i,
	input  bus_mem_pkg::bus_dat_t dat_i,
	input  bus_mem_pkg::bus_sel_t sel_i,
	output bus_mem_pkg::bus_dat_t dat_o,
	output logic                  ack_o
);

	import bus_mem_pkg::*;

	bus_dat_t                         mem [DEPTH_WORDS];
	logic [$clog2(DEPTH_WORDS)-1:0]   word_idx;
	logic                             access;

	// word address wraps at the depth, so the slot aliases
	assign word_idx = adr_i[WORD_LSB +: $clog2(DEPTH_WORDS)];

	// one access per strobe, the ack cycle itself is skipped
	assign access = stb_i && !ack_o;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= access;
		end
	end

	always_ff @(posedge clk_i) begin
		if (access) begin
			if (we_i) begin
				for (int b = 0; b < SEL_WIDTH; b++) begin
					if (sel_i[b]) begin
						mem[word_idx][8*b +: 8] <= dat_i[8*b +: 8];
					end
				end
			end else begin
				dat_o <= mem[word_idx];
			end
		end
	end

	// single cycle ack even with strobe still high
	assert property (@(posedge clk_i) disable iff (!arst_n_i) ack_o |=> !ack_o)
		else $error("ram: ack held for two cycles");

endmodule

//--- design/bus_reg_slave.sv
`timescale 1ns/1ps

module bus_reg_slave (
	input  logic                  clk_i,
	input  logic                  arst_n_i,
	input  logic                  stb_i,
	input  logic                  we_i,
	input  bus_mem_pkg::bus_adr_t adr_i,
	input  bus_mem_pkg::bus_dat_t dat_i,
	input  bus_mem_pkg::bus_sel_t sel_i,
	input  bus_mem_pkg::gpio_t    gpio_i,
	output bus_mem_pkg::bus_dat_t dat_o,
	output logic                  ack_o,
	output bus_mem_pkg::gpio_t    gpio_o
);

	import bus_mem_pkg::*;

	reg_ofs_t reg_ofs;
	logic     access;
	gpio_t    gpio_out_q;
	gpio_t    gpio_meta_q;
	gpio_t    gpio_sync_q;
	gpio_t    gpio_in_q;
	bus_dat_t scratch_q;
	bus_dat_t rd_word;

	// higher offsets alias onto the four registers
	assign reg_ofs = adr_i[WORD_LSB +: $bits(reg_ofs_t)];
	assign access = stb_i && !ack_o;

	// gpio_i is asynchronous to clk_i
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			gpio_meta_q <= '0;
			gpio_sync_q <= '0;
			gpio_in_q <= '0;
		end else begin
			gpio_meta_q <= gpio_i;
			gpio_sync_q <= gpio_meta_q;
			gpio_in_q <= gpio_sync_q;
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_o <= 1'b0;
			gpio_out_q <= '0;
			scratch_q <= '0;
		end else begin
			ack_o <= access;
			if (access && we_i) begin
				case (reg_ofs)
					REG_GPIO_OUT: begin
						if (sel_i[0]) begin
							gpio_out_q <= dat_i[GPIO_WIDTH-1:0];
						end
					end
					REG_SCRATCH: begin
						for (int b = 0; b < SEL_WIDTH; b++) begin
							if (sel_i[b]) begin
								scratch_q[8*b +: 8] <= dat_i[8*b +: 8];
							end
						end
					end
					// gpio in and id are read only
					default: begin
					end
				endcase
			end
		end
	end

	always_comb begin
		rd_word = '0;
		case (reg_ofs)
			REG_GPIO_OUT: rd_word = bus_dat_t'(gpio_out_q);
			REG_GPIO_IN:  rd_word = bus_dat_t'(gpio_in_q);
			REG_SCRATCH:  rd_word = scratch_q;
			REG_ID:       rd_word = REG_ID_VALUE;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (access && !we_i) begin
			dat_o <= rd_word;
		end
	end

	assign gpio_o = gpio_out_q;

endmodule

//--- design/bus_mem_top.sv
`timescale 1ns/1ps

module bus_mem_top (
	input  logic                  clk_i,
	input  logic                  arst_n_i,

	// master
	input  logic                  master_stb_i,
	input  logic                  master_we_i,
	input  bus_mem_pkg::bus_adr_t master_adr_i,
	input  bus_mem_pkg::bus_dat_t master_dat_i,
	input  bus_mem_pkg::bus_sel_t master_sel_i,
	output bus_mem_pkg::bus_dat_t master_dat_o,
	output logic                  master_ack_o,
	output logic                  adr_err_o,

	// gpio pins
	input  bus_mem_pkg::gpio_t    gpio_i,
	output bus_mem_pkg::gpio_t    gpio_o,

	// external slave in slot 3
	input  bus_mem_pkg::bus_dat_t ext_dat_i,
	input  logic                  ext_ack_i,
	output logic                  ext_stb_o,
	output logic                  ext_cyc_o,
	output logic                  ext_we_o,
	output bus_mem_pkg::bus_adr_t ext_adr_o,
	output bus_mem_pkg::bus_dat_t ext_dat_o,
	output bus_mem_pkg::bus_sel_t ext_sel_o
);

	import bus_mem_pkg::*;

	slave_cs_t                  slave_stb;
	logic                       slave_we;
	bus_adr_t                   slave_adr;
	bus_dat_t                   slave_wdat;
	bus_sel_t                   slave_sel;
	wire bus_dat_t [SLAVE_NUMBER-1:0] slave_rdat;
	wire slave_cs_t             slave_ack;

	bus_switch bus_switch_i (
		.master_stb_i (master_stb_i),
		.master_we_i  (master_we_i),
		.master_adr_i (master_adr_i),
		.master_dat_i (master_dat_i),
		.master_sel_i (master_sel_i),
		.master_dat_o (master_dat_o),
		.master_ack_o (master_ack_o),
		.adr_err_o    (adr_err_o),
		.slave_stb_o  (slave_stb),
		.slave_we_o   (slave_we),
		.slave_adr_o  (slave_adr),
		.slave_dat_o  (slave_wdat),
		.slave_sel_o  (slave_sel),
		.slave_dat_i  (slave_rdat),
		.slave_ack_i  (slave_ack)
	);

	bus_ram_slave #(
		.DEPTH_WORDS (RAM0_WORDS)
	) bus_ram0_i (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.stb_i    (slave_stb[SLOT_RAM0]),
		.we_i     (slave_we),
		.adr_i    (slave_adr),
		.dat_i    (slave_wdat),
		.sel_i    (slave_sel),
		.dat_o    (slave_rdat[SLOT_RAM0]),
		.ack_o    (slave_ack[SLOT_RAM0])
	);

	bus_ram_slave #(
		.DEPTH_WORDS (RAM1_WORDS)
	) bus_ram1_i (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.stb_i    (slave_stb[SLOT_RAM1]),
		.we_i     (slave_we),
		.adr_i    (slave_adr),
		.dat_i    (slave_wdat),
		.sel_i    (slave_sel),
		.dat_o    (slave_rdat[SLOT_RAM1]),
		.ack_o    (slave_ack[SLOT_RAM1])
	);

	bus_reg_slave bus_reg_slave_i (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.stb_i    (slave_stb[SLOT_REG]),
		.we_i     (slave_we),
		.adr_i    (slave_adr),
		.dat_i    (slave_wdat),
		.sel_i    (slave_sel),
		.gpio_i   (gpio_i),
		.dat_o    (slave_rdat[SLOT_REG]),
		.ack_o    (slave_ack[SLOT_REG]),
		.gpio_o   (gpio_o)
	);

	// slot 3 leaves the chip
	assign ext_stb_o = slave_stb[SLOT_EXT];
	assign ext_cyc_o = slave_stb[SLOT_EXT];
	assign ext_we_o = slave_we;
	assign ext_adr_o = slave_adr;
	assign ext_dat_o = slave_wdat;
	assign ext_sel_o = slave_sel;
	assign slave_rdat[SLOT_EXT] = ext_dat_i;
	assign slave_ack[SLOT_EXT] = ext_ack_i;

endmodule

//--- tb/tb_bus_mem_top.sv
`timescale 1ns/1ps

module tb_bus_mem_top;

	import bus_mem_pkg::*;

	localparam time         CLK_PERIOD = 100;
	localparam int unsigned RESET_CYCLES = 10;
	localparam int unsigned ACK_TIMEOUT = 20;
	localparam int unsigned GPIO_SETTLE = 4;
	localparam int unsigned MAX_TOKENS = 1000;
	localparam logic [31:0] SEED = 32'h1baf_c074;

	logic     clk = 1'b0;
	logic     arst_n = 1'b0;
	logic     master_stb = 1'b0;
	logic     master_we = 1'b0;
	bus_adr_t master_adr = '0;
	bus_dat_t master_wdat = '0;
	bus_sel_t master_sel = '0;
	bus_dat_t master_rdat;
	logic     master_ack;
	logic     adr_err;
	gpio_t    gpio_in = '0;
	gpio_t    gpio_out;
	bus_dat_t ext_rdat = '0;
	logic     ext_ack = 1'b0;
	logic     ext_stb;
	logic     ext_cyc;
	logic     ext_we;
	bus_adr_t ext_adr;
	bus_dat_t ext_wdat;
	bus_sel_t ext_sel;

	// external slave model
	bus_dat_t    ext_mem [16];
	logic        ext_stb_q = 1'b0;
	logic        ext_busy = 1'b0;
	int unsigned ext_delay = 0;

	int unsigned checks = 0;
	int unsigned errors = 0;
	logic        timed_out = 1'b0;
	gpio_t       gpio_exp = '0;

	bus_mem_top bus_mem_top_i (
		.clk_i        (clk),
		.arst_n_i     (arst_n),
		.master_stb_i (master_stb),
		.master_we_i  (master_we),
		.master_adr_i (master_adr),
		.master_dat_i (master_wdat),
		.master_sel_i (master_sel),
		.master_dat_o (master_rdat),
		.master_ack_o (master_ack),
		.adr_err_o    (adr_err),
		.gpio_i       (gpio_in),
		.gpio_o       (gpio_out),
		.ext_dat_i    (ext_rdat),
		.ext_ack_i    (ext_ack),
		.ext_stb_o    (ext_stb),
		.ext_cyc_o    (ext_cyc),
		.ext_we_o     (ext_we),
		.ext_adr_o    (ext_adr),
		.ext_dat_o    (ext_wdat),
		.ext_sel_o    (ext_sel)
	);

	always begin
		#(CLK_PERIOD / 2);
		clk = ~clk;
	end

	always @(posedge clk) begin
		ext_stb_q <= ext_stb;
	end

	// one-cycle ack after a random delay over an aliased 16 word memory
	always @(negedge clk) begin
		if (!arst_n) begin
			ext_ack = 1'b0;
			ext_busy = 1'b0;
		end else if (ext_ack) begin
			ext_ack = 1'b0;
		end else if (ext_busy) begin
			if (ext_delay > 1) begin
				ext_delay = ext_delay - 1;
			end else begin
				if (ext_we) begin
					for (int b = 0; b < 4; b++) begin
						if (ext_sel[b]) begin
							ext_mem[ext_adr[5:2]][8*b +: 8] = ext_wdat[8*b +: 8];
						end
					end
				end else begin
					ext_rdat = ext_mem[ext_adr[5:2]];
				end
				ext_ack = 1'b1;
				ext_busy = 1'b0;
			end
		end else if (ext_stb_q) begin
			ext_busy = 1'b1;
			ext_delay = 1 + ($urandom % 4);
		end
	end

	task automatic expect_equal(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic run_access(input logic we, input bus_adr_t adr, input bus_dat_t wdat,
		input bus_sel_t sel, input bus_dat_t exp_rdat, input logic exp_err);
		int unsigned cyc;
		logic        done;
		logic        to_ext;
		logic        internal;
		to_ext = (adr[31:16] == 16'h0) && (adr[15:12] == 4'd3);
		internal = !exp_err && !to_ext;
		@(negedge clk);
		master_stb = 1'b1;
		master_we = we;
		master_adr = adr;
		master_wdat = wdat;
		master_sel = sel;
		done = 1'b0;
		cyc = 0;
		while (!done && cyc < ACK_TIMEOUT) begin
			// settle point ahead of the rising edge
			#(CLK_PERIOD / 4);
			expect_equal("ext_cyc_o", ext_cyc, to_ext);
			expect_equal("ext_stb_o", ext_stb, to_ext);
			if (exp_err) begin
				expect_equal("adr_err_o", adr_err, 1'b1);
				expect_equal("master_ack_o", master_ack, 1'b0);
				expect_equal("slave strobes", bus_mem_top_i.slave_stb, '0);
				// master gives up after two cycles
				if (cyc == 1) begin
					done = 1'b1;
				end
			end else begin
				expect_equal("adr_err_o", adr_err, 1'b0);
				if (to_ext) begin
					expect_equal("ext_we_o", ext_we, we);
					expect_equal("ext_adr_o", ext_adr, adr);
					expect_equal("ext_sel_o", ext_sel, sel);
					if (we) begin
						expect_equal("ext_dat_o", ext_wdat, wdat);
					end
				end
				if (internal) begin
					expect_equal("internal ack latency", master_ack, cyc == 1);
				end
				if (master_ack) begin
					if (!we) begin
						expect_equal("master_dat_o", master_rdat, exp_rdat);
					end
					done = 1'b1;
				end
			end
			if (!done) begin
				@(negedge clk);
				cyc++;
			end
		end
		if (!done) begin
			$display("timeout: no ack for address %h within %0d cycles", adr, ACK_TIMEOUT);
			errors++;
			timed_out = 1'b1;
		end
		if (done && internal) begin
			// past the next rising edge with strobe still high
			#(CLK_PERIOD / 2);
			expect_equal("internal ack length", master_ack, 1'b0);
		end
		@(negedge clk);
		master_stb = 1'b0;
		master_we = 1'b0;
		#(CLK_PERIOD / 4);
		expect_equal("ack after strobe drop", master_ack, 1'b0);
		expect_equal("adr_err_o after strobe drop", adr_err, 1'b0);
		if (we && !exp_err && adr[31:16] == 16'h0 && adr[15:12] == 4'd2
			&& adr[3:2] == 2'd0 && sel[0]) begin
			gpio_exp = wdat[7:0];
		end
		expect_equal("gpio_o", gpio_out, gpio_exp);
	endtask

	task automatic set_gpio(input gpio_t value);
		@(negedge clk);
		gpio_in = value;
		// synchronizer needs a few edges
		for (int i = 0; i < GPIO_SETTLE; i++) begin
			@(negedge clk);
		end
	endtask

	task automatic finish_run();
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	initial begin
		logic [31:0]      seed_val;
		int               fd;
		int               n;
		int unsigned      tokens;
		logic [8*8-1:0]   op_tok;
		logic [8*160-1:0] rest;
		bus_adr_t         f_adr;
		bus_dat_t         f_wdat;
		bus_sel_t         f_sel;
		bus_dat_t         f_exp;
		logic             f_err;
		seed_val = $urandom(SEED);
		tokens = 0;
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge clk);
		end
		@(negedge clk);
		arst_n = 1'b1;
		expect_equal("gpio_o after reset", gpio_out, '0);
		fd = $fopen("tb/bus_input.txt", "r");
		if (fd == 0) begin
			$display("could not open tb/bus_input.txt");
			errors++;
		end else begin
			while (!timed_out && tokens < MAX_TOKENS) begin
				n = $fscanf(fd, "%s", op_tok);
				if (n != 1) begin
					break;
				end
				tokens++;
				if (op_tok == "#") begin
					n = $fgets(rest, fd);
				end else begin
					n = $fscanf(fd, "%h %h %h %h %h", f_adr, f_wdat, f_sel, f_exp, f_err);
					if (n != 5) begin
						$display("malformed line in input file after %0d entries", tokens);
						errors++;
						break;
					end
					if (op_tok == "W") begin
						run_access(1'b1, f_adr, f_wdat, f_sel, f_exp, f_err);
					end else if (op_tok == "R") begin
						run_access(1'b0, f_adr, f_wdat, f_sel, f_exp, f_err);
					end else if (op_tok == "G") begin
						set_gpio(f_wdat[7:0]);
					end else begin
						$display("unknown operation in input file: %s", op_tok);
						errors++;
					end
				end
			end
			$fclose(fd);
		end
		finish_run();
	end

endmodule

//--- tb/bus_input.txt
# columns: op addr wdata sel exp_rdata exp_err, all hex
# op W write, R read, G drive gpio_i with the low byte of wdata
R 00002008 00000000 f 00000000 0
R 00002000 00000000 f 00000000 0
W 00000010 11223344 f 00000000 0
R 00000010 00000000 f 11223344 0
W 00000010 aabbccdd 5 00000000 0
R 00000010 00000000 f 11bb33dd 0
R 00000410 00000000 f 11bb33dd 0
W 000003fc cafef00d f 00000000 0
R 000003fc 00000000 f cafef00d 0
W 00001020 01020304 f 00000000 0
R 00001020 00000000 f 01020304 0
R 00001120 00000000 f 01020304 0
W 00001120 a0b0c0d0 8 00000000 0
R 00001020 00000000 f a0020304 0
W 00002000 000000a5 1 00000000 0
R 00002000 00000000 f 000000a5 0
W 00002000 ffffff3c e 00000000 0
R 00002000 00000000 f 000000a5 0
R 0000200c 00000000 f 42555331 0
W 0000200c 12345678 f 00000000 0
R 0000200c 00000000 f 42555331 0
W 00002008 deadbeef f 00000000 0
W 00002008 00110000 4 00000000 0
R 00002008 00000000 f de11beef 0
R 00002018 00000000 f de11beef 0
G 00000000 0000005a 0 00000000 0
R 00002004 00000000 f 0000005a 0
W 00002004 ffffffff f 00000000 0
R 00002004 00000000 f 0000005a 0
W 00003000 87654321 f 00000000 0
W 00003004 0badf00d f 00000000 0
R 00003000 00000000 f 87654321 0
W 00003004 00ee0000 4 00000000 0
R 00003004 00000000 f 0beef00d 0
R 00003040 00000000 f 87654321 0
R 00004000 00000000 f 00000000 1
W 0000f000 55555555 f 00000000 1
R 00010000 00000000 f 00000000 1
R 80003000 00000000 f 00000000 1
R 00000010 00000000 f 11bb33dd 0

//--- sim.f
design/bus_mem_pkg.sv
design/bus_slave_selector.sv
design/bus_switch.sv
design/bus_ram_slave.sv
design/bus_reg_slave.sv
design/bus_mem_top.sv
tb/tb_bus_mem_top.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the bus_mem_top testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot enter project directory"
	exit 1
fi

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing -Wno-fatal \
	--top-module tb_bus_mem_top \
	-f sim.f \
	-Mdir "$OBJ_DIR" -o sim_bin
if [ $? -ne 0 ]; then
	echo "compilation failed"
	exit 1
fi

"./$OBJ_DIR/sim_bin" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
